/* rvSystem.f */
rvCorePkg.sv
control.sv
aluUnit.sv
regFile.sv
memArbiter.sv
unifiedMem.sv
coreSeq.sv
rvSystem.sv
tbClock.sv
tbRvSystem.sv

/* run.sh */
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbRvSystem -f rvSystem.f -o simRvSystem

./obj_dir/simRvSystem | tee sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0

/* tbRvSystem.sv */
`default_nettype none

module tbRvSystem import rvCorePkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int progLen   = 96;
  localparam int dataWords = 16;
  localparam logic [xlen-1:0] dataBase = 32'h800; // x1 after setup
  localparam logic [xlen-1:0] hostBase = 32'hE00; // not touched by the program
  localparam int periodNs  = 40;
  localparam int watchNs   = periodNs * (200 * progLen + progLen + dataWords + 100);

  logic clk, rstN;
  logic hostReq, hostWe, hostGnt;
  logic [xlen-1:0] hostAddr, hostWdata;
  logic retire, retireStore, halted;
  logic [4:0] retireRd;
  logic [xlen-1:0] retirePc, retireValue, retireAddr, retireData;

  integer seed = 9511;
  logic [xlen-1:0] prog [progLen];
  logic [xlen-1:0] refMem [1024];
  logic [xlen-1:0] xr [32];
  logic resValid;
  logic [xlen-1:0] resAddr;
  int gi;
  logic loading;
  string curTest;
  int testErr, errCount, failedTests, testsRun, checks;
  int hostHits, scPassSeen, scFailSeen, retireCount;

  // expected retire trace with one entry per instruction
  logic [xlen-1:0] expPc[$], expVal[$], expAddr[$], expData[$];
  logic [4:0] expRd[$];
  logic expStore[$], expSc[$];

  tbClock #(.periodNs(periodNs), .resetCycles(8)) tbClock_i (.clk(clk), .rstN(rstN));

  rvSystem #(.memWords(1024), .resetPc(32'h0)) rvSystem_i (
    .clk(clk), .rstN(rstN), .hostReq(hostReq), .hostWe(hostWe), .hostAddr(hostAddr),
    .hostWdata(hostWdata), .hostGnt(hostGnt), .retire(retire), .retirePc(retirePc),
    .retireRd(retireRd), .retireValue(retireValue), .retireStore(retireStore),
    .retireAddr(retireAddr), .retireData(retireData), .halted(halted)
  );

  function automatic int unsigned rnd(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [4:0] randRd();
    return 5'(3 + rnd(29)); // never x0, x1 or x2
  endfunction

  function automatic logic [4:0] randReg();
    return 5'(rnd(32));
  endfunction

  function automatic logic [xlen-1:0] fillWord(logic [xlen-1:0] a);
    return (a * 32'h9E3779B1) ^ {a[15:0], ~a[15:0]};
  endfunction

  function automatic logic [xlen-1:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    rvInstr_t w;
    w.rType = '{f7, rs2, rs1, f3, rd, op};
    return w.raw;
  endfunction

  function automatic logic [xlen-1:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
    rvInstr_t w;
    w.iType = '{imm, rs1, f3, rd, op};
    return w.raw;
  endfunction

  function automatic logic [xlen-1:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    rvInstr_t w;
    w.sType = '{imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    return w.raw;
  endfunction

  function automatic logic [xlen-1:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    rvInstr_t w;
    w.sType = '{{imm[12], imm[10:5]}, rs2, rs1, f3, {imm[4:1], imm[11]}, opBranch};
    return w.raw;
  endfunction

  function automatic logic [xlen-1:0] encJ(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
  endfunction

  task automatic emit(logic [xlen-1:0] w);
    prog[gi] = w;
    gi++;
  endtask

  // variant 0 pairs LR and SC, 1 puts a SW between them, 2 is a lone SC
  task automatic emitAtomic(int v);
    logic [11:0] off;
    off = 12'(4 * rnd(dataWords));
    emit(encI(off, 5'd1, 3'b000, 5'd2, opOpImm));
    if (v != 2) emit(encR({amoLr, 2'b00}, 5'd0, 5'd2, 3'b010, randRd(), opAmo));
    if (v == 1) emit(encS(off, randReg(), 5'd1));
    emit(encR({amoSc, 2'b00}, randReg(), 5'd2, 3'b010, randRd(), opAmo));
  endtask

  task automatic buildProgram();
    int kind, k, f3, imm;
    gi = 0;
    emit({20'h1, 5'd1, opLui});
    emit(encI(12'h800, 5'd1, 3'b000, 5'd1, opOpImm)); // x1 = 0x800
    emit(encI(12'h000, 5'd1, 3'b000, 5'd2, opOpImm));
    for (int v = 0; v < 3; v++) emitAtomic(v); // before any branch can skip them
    while (gi < progLen - 5) begin
      kind = rnd(16);
      case (kind)
        0, 1, 2, 3: begin
          f3 = rnd(8);
          emit(encR(((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 7'h20 : 7'h00, randReg(),
                    randReg(), 3'(f3), randRd(), opOp));
        end
        4, 5, 6, 7: begin
          f3 = rnd(8);
          if (f3 == 1) imm = rnd(32);
          else if (f3 == 5) imm = rnd(32) | (rnd(2) << 10); // srli or srai
          else imm = rnd(4096);
          emit(encI(12'(imm), randReg(), 3'(f3), randRd(), opOpImm));
        end
        8:  emit({20'(rnd(1 << 20)), randRd(), opLui});
        9:  emit({20'(rnd(1 << 20)), randRd(), opAuipc});
        10, 11: emit(encI(12'(4 * rnd(dataWords)), 5'd1, 3'b010, randRd(), opLoad));
        12: emit(encS(12'(4 * rnd(dataWords)), randReg(), 5'd1));
        13: emitAtomic(rnd(3));
        14: begin
          k = 1 + rnd(3);
          f3 = rnd(6);
          if (f3 >= 2) f3 += 2; // skip the unused func3 codes
          emit(encB(13'(4 * (k + 1)), randReg(), randReg(), 3'(f3)));
        end
        default: begin
          k = 1 + rnd(3);
          if (rnd(2) == 1) emit(encJ(21'(4 * (k + 1)), randRd()));
          else emit(encI(12'(4 * (gi + k + 1)), 5'd0, 3'b000, randRd(), opJalr)); // absolute
        end
      endcase
    end
    while (gi < progLen - 1) emit(encI(12'(rnd(4096)), randReg(), 3'b000, randRd(), opOpImm));
    emit(32'h00000073); // ecall
  endtask

  function automatic logic [xlen-1:0] refAlu(logic [2:0] f3, logic alt, logic [xlen-1:0] a,
                                             logic [xlen-1:0] b, logic isReg);
    logic [xlen-1:0] r;
    case (f3)
      3'b000: r = (isReg && alt) ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: r = (a < b) ? 32'd1 : 32'd0;
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branchTaken(logic [2:0] f3, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // ISA model run ahead of the DUT to build the expected trace
  task automatic runModel();
    logic [xlen-1:0] pc, ins, a, b, addr, val, npc;
    logic [xlen-1:0] immI, immS, immB, immJ;
    logic [4:0] rd;
    logic store, sc, ok, done;
    int steps;
    for (int r = 0; r < 32; r++) xr[r] = '0;
    resValid = 1'b0;
    resAddr = '0;
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 4 * progLen) begin
      ins = prog[pc[8:2]];
      a = xr[ins[19:15]];
      b = xr[ins[24:20]];
      immI = {{20{ins[31]}}, ins[31:20]};
      immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      rd = ins[11:7];
      val = '0;
      addr = '0;
      store = 1'b0;
      sc = 1'b0;
      npc = pc + 4;
      case (ins[6:0])
        opLui:   val = {ins[31:12], 12'b0};
        opAuipc: val = pc + {ins[31:12], 12'b0};
        opOp:    val = refAlu(ins[14:12], ins[30], a, b, 1'b1);
        opOpImm: val = refAlu(ins[14:12], ins[30], a, immI, 1'b0);
        opLoad: begin
          addr = a + immI;
          val = refMem[addr[11:2]];
        end
        opStore: begin
          addr = a + immS;
          store = 1'b1;
          rd = '0;
          refMem[addr[11:2]] = b;
          if (addr == resAddr) resValid = 1'b0; // sw breaks the reservation
        end
        opBranch: begin
          rd = '0;
          if (branchTaken(ins[14:12], a, b)) npc = pc + immB;
        end
        opJal: begin
          val = pc + 4;
          npc = pc + immJ;
        end
        opJalr: begin
          val = pc + 4;
          npc = (a + immI) & ~32'h1;
        end
        opAmo: begin
          addr = a;
          if (ins[31:27] == amoLr) begin
            val = refMem[addr[11:2]];
            resValid = 1'b1;
            resAddr = addr;
          end else begin
            sc = 1'b1;
            ok = resValid && (resAddr == addr);
            if (ok) refMem[addr[11:2]] = b;
            store = ok;
            val = ok ? 32'd0 : 32'd1;
            resValid = 1'b0;
          end
        end
        default: begin
          rd = '0;
          done = 1'b1; // ecall
        end
      endcase
      if (rd != 5'd0) xr[rd] = val;
      expPc.push_back(pc);
      expRd.push_back(rd);
      expVal.push_back(val);
      expStore.push_back(store);
      expAddr.push_back(addr);
      expData.push_back(b);
      expSc.push_back(sc);
      pc = npc;
      steps++;
    end
  endtask

  task automatic noteError();
    testErr++;
    errCount++;
  endtask

  task automatic compareWord(string what, logic [xlen-1:0] exp, logic [xlen-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("Error %s (%s): expected %h, actual %h", curTest, what, exp, act);
      noteError();
    end
  endtask

  task automatic compareReg(string what, logic [4:0] exp, logic [4:0] act);
    checks++;
    if (act !== exp) begin
      $display("Error %s (%s): expected x%0d, actual x%0d", curTest, what, exp, act);
      noteError();
    end
  endtask

  task automatic compareBit(string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      $display("Error %s (%s): expected %b, actual %b", curTest, what, exp, act);
      noteError();
    end
  endtask

  task automatic startTest(string name);
    curTest = name;
    testErr = 0;
  endtask

  task automatic endTest();
    testsRun++;
    if (testErr != 0) failedTests++;
    $display("test %s %s (%0d errors)", curTest, (testErr == 0) ? "ok" : "FAILED", testErr);
  endtask

  // called just after a rising edge, returns at the edge that does the write
  task automatic hostWrite(logic [xlen-1:0] addr, logic [xlen-1:0] data);
    logic late;
    late = 1'b0;
    hostReq   <= 1'b1;
    hostWe    <= 1'b1;
    hostAddr  <= addr;
    hostWdata <= data;
    do begin
      @(negedge clk);
      if (loading && (retire || halted)) begin
        $display("%s: the core retired or halted while the program was loading", curTest);
        noteError();
      end
      if (!hostGnt && !late) begin
        $display("%s: the host write to %h was not granted in its first cycle", curTest, addr);
        noteError();
        late = 1'b1;
      end
    end while (!hostGnt);
    @(posedge clk);
  endtask

  task automatic contendHost();
    logic stop;
    stop = 1'b0;
    while (!stop) begin
      repeat (1 + rnd(8)) @(negedge clk);
      if (halted) begin
        stop = 1'b1;
      end else begin
        @(posedge clk);
        hostWrite(hostBase + 32'(4 * rnd(128)), $random(seed));
        hostReq <= 1'b0;
        hostHits++;
      end
    end
  endtask

  task automatic checkRetire();
    int n;
    n = retireCount;
    if (n >= expPc.size()) begin
      $display("%s: retire at pc %h after the expected end of the program", curTest, retirePc);
      noteError();
    end else begin
      compareWord("pc", expPc[n], retirePc);
      compareReg("rd", expRd[n], retireRd);
      if (expRd[n] != 5'd0) compareWord("value", expVal[n], retireValue);
      compareBit("store", expStore[n], retireStore);
      if (expStore[n]) begin
        compareWord("store address", expAddr[n], retireAddr);
        compareWord("store data", expData[n], retireData);
      end
      if (expSc[n] && retireStore) scPassSeen++;
      else if (expSc[n]) scFailSeen++;
    end
    retireCount++;
  endtask

  task automatic watchRetires();
    while (!halted) begin
      @(negedge clk);
      if (retire) checkRetire();
    end
  endtask

  initial begin
    #(watchNs);
    $display("run stopped by the watchdog, the core did not halt in time");
    $display("Verification failed");
    $finish;
  end

  initial begin
    hostReq = 1'b0;
    hostWe = 1'b0;
    hostAddr = '0;
    hostWdata = '0;
    loading = 1'b1;
    testsRun = 0;
    failedTests = 0;
    errCount = 0;
    checks = 0;
    hostHits = 0;
    scPassSeen = 0;
    scFailSeen = 0;
    retireCount = 0;
    buildProgram();
    for (int i = 0; i < dataWords; i++) refMem[dataBase[11:2] + i] = fillWord(dataBase + 4 * i);
    runModel();

    startTest("loadIdle");
    @(posedge clk);
    for (int i = 0; i < progLen; i++) hostWrite(32'(4 * i), prog[i]);
    for (int i = 0; i < dataWords; i++) hostWrite(dataBase + 4 * i, fillWord(dataBase + 4 * i));
    hostReq <= 1'b0; // core gets its first fetch from here on
    loading = 1'b0;
    endTest();

    startTest("retireTrace");
    fork
      contendHost();
      watchRetires();
    join
    endTest();

    startTest("atomicMix");
    if (scPassSeen == 0 || scFailSeen == 0) begin
      $display("%s: SC success and SC failure were not both seen", curTest);
      noteError();
    end
    endTest();

    startTest("hostContention");
    if (hostHits == 0) begin
      $display("%s: no host write happened while the core was running", curTest);
      noteError();
    end
    endTest();

    startTest("haltEnd");
    repeat (50) begin
      @(negedge clk);
      compareBit("halted", 1'b1, halted);
      if (retire) begin
        $display("%s: retire at pc %h after halted rose", curTest, retirePc);
        noteError();
      end
    end
    compareWord("retire count", 32'(expPc.size()), 32'(retireCount));
    endTest();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             testsRun, failedTests, checks, errCount);
    if (errCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tbClock.sv */
`default_nettype none

module tbClock #(
  parameter int periodNs    = 40,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1; // released on a rising edge
  end

endmodule

`default_nettype wire

/* rvSystem.sv */
`default_nettype none

module rvSystem import rvCorePkg::*; #(
  parameter int              memWords = 1024,
  parameter logic [xlen-1:0] resetPc  = '0
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            hostReq,
  input  logic            hostWe,
  input  logic [xlen-1:0] hostAddr,
  input  logic [xlen-1:0] hostWdata,
  output logic            hostGnt,
  output logic            retire,
  output logic [xlen-1:0] retirePc,
  output logic [4:0]      retireRd,
  output logic [xlen-1:0] retireValue,
  output logic            retireStore,
  output logic [xlen-1:0] retireAddr,
  output logic [xlen-1:0] retireData,
  output logic            halted
);

  logic fetchReq, fetchGnt, fetchRvalid;
  logic dataReq, dataWe, dataGnt, dataRvalid;
  logic [xlen-1:0] fetchAddr, fetchRdata;
  logic [xlen-1:0] dataAddr, dataWdata, dataRdata;
  logic memEn, memWe;
  logic [$clog2(memWords)-1:0] memAddr;
  logic [xlen-1:0] memWdata, memRdata;

  coreSeq #(.memWords(memWords), .resetPc(resetPc)) coreSeq_i (
    .clk(clk), .rstN(rstN),
    .fetchGnt(fetchGnt), .fetchRvalid(fetchRvalid), .fetchRdata(fetchRdata),
    .dataGnt(dataGnt), .dataRvalid(dataRvalid), .dataRdata(dataRdata),
    .fetchReq(fetchReq), .fetchAddr(fetchAddr),
    .dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr), .dataWdata(dataWdata),
    .retire(retire), .retirePc(retirePc), .retireRd(retireRd), .retireValue(retireValue),
    .retireStore(retireStore), .retireAddr(retireAddr), .retireData(retireData),
    .halted(halted)
  );

  memArbiter #(.memWords(memWords)) memArbiter_i (
    .clk(clk), .rstN(rstN),
    .hostReq(hostReq), .hostWe(hostWe), .hostAddr(hostAddr), .hostWdata(hostWdata),
    .fetchReq(fetchReq), .fetchAddr(fetchAddr),
    .dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr), .dataWdata(dataWdata),
    .memRdata(memRdata), .hostGnt(hostGnt),
    .fetchGnt(fetchGnt), .fetchRvalid(fetchRvalid), .fetchRdata(fetchRdata),
    .dataGnt(dataGnt), .dataRvalid(dataRvalid), .dataRdata(dataRdata),
    .memEn(memEn), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
  );

  unifiedMem #(.memWords(memWords)) unifiedMem_i (
    .clk(clk), .en(memEn), .we(memWe), .addr(memAddr), .wdata(memWdata), .rdata(memRdata)
  );

endmodule

`default_nettype wire

/* coreSeq.sv */
`default_nettype none

module coreSeq import rvCorePkg::*; #(
  parameter int              memWords = 1024,
  parameter logic [xlen-1:0] resetPc  = '0
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            fetchGnt,
  input  logic            fetchRvalid,
  input  logic [xlen-1:0] fetchRdata,
  input  logic            dataGnt,
  input  logic            dataRvalid,
  input  logic [xlen-1:0] dataRdata,
  output logic            fetchReq,
  output logic [xlen-1:0] fetchAddr,
  output logic            dataReq,
  output logic            dataWe,
  output logic [xlen-1:0] dataAddr,
  output logic [xlen-1:0] dataWdata,
  output logic            retire,
  output logic [xlen-1:0] retirePc,
  output logic [4:0]      retireRd,
  output logic [xlen-1:0] retireValue,
  output logic            retireStore,
  output logic [xlen-1:0] retireAddr,
  output logic [xlen-1:0] retireData,
  output logic            halted
);

  localparam logic [2:0] stIdle      = 3'd0;
  localparam logic [2:0] stFetch     = 3'd1;
  localparam logic [2:0] stFetchWait = 3'd2;
  localparam logic [2:0] stExecute   = 3'd3;
  localparam logic [2:0] stMem       = 3'd4;
  localparam logic [2:0] stMemWait   = 3'd5;
  localparam logic [2:0] stWriteback = 3'd6;

  logic [2:0]      state;
  logic [xlen-1:0] pc;
  rvInstr_t        ir;
  logic [xlen-1:0] loadData;
  logic            resValid;
  logic [xlen-1:0] resAddr;

  logic branch, jump, jumpRegister, memRead, memToReg, memWrite;
  logic aluSrc, pcToAlu, regWrite, isLr, isSc, halt;
  aluOp_t          aluOp;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rdata1, rdata2;
  logic [xlen-1:0] aluA, aluB, aluResult;
  logic            taken;
  logic            scOk;
  logic            storeDone;
  logic [xlen-1:0] nextPc;
  logic [xlen-1:0] wbValue;

  control control_i (
    .instr(ir), .branch(branch), .jump(jump), .jumpRegister(jumpRegister),
    .memRead(memRead), .memToReg(memToReg), .memWrite(memWrite), .aluSrc(aluSrc),
    .pcToAlu(pcToAlu), .regWrite(regWrite), .aluOp(aluOp), .imm(imm),
    .isLr(isLr), .isSc(isSc), .halt(halt)
  );

  regFile regFile_i (
    .clk(clk), .rstN(rstN), .rs1(ir.rType.rs1), .rs2(ir.rType.rs2), .rd(ir.rType.rd),
    .we(retire && regWrite), .wdata(wbValue), .rdata1(rdata1), .rdata2(rdata2)
  );

  assign aluA = pcToAlu ? pc : rdata1;
  assign aluB = aluSrc ? imm : rdata2;

  aluUnit aluUnit_i (
    .aluOp(aluOp), .func3(ir.rType.func3), .func7(ir.rType.func7),
    .a(aluA), .b(aluB), .result(aluResult), .taken(taken)
  );

  // operands stay stable from Execute to Writeback, regs change only at retire
  assign scOk      = resValid && (resAddr == aluResult);
  assign storeDone = memWrite && (!isSc || scOk);

  always_comb begin
    if (jump) nextPc = jumpRegister ? {aluResult[xlen-1:1], 1'b0} : aluResult;
    else if (branch && taken) nextPc = pc + imm;
    else nextPc = pc + 4;
  end

  always_comb begin
    if (memToReg) wbValue = loadData;
    else if (jump) wbValue = pc + 4; // link
    else if (isSc) wbValue = {{(xlen-1){1'b0}}, !scOk};
    else wbValue = aluResult;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state    <= stIdle;
      pc       <= resetPc;
      halted   <= 1'b0;
      resValid <= 1'b0;
    end else begin
      case (state)
        stIdle:      if (!halted) state <= stFetch;
        stFetch:     if (fetchGnt) state <= stFetchWait;
        stFetchWait: if (fetchRvalid) state <= stExecute;
        stExecute:   state <= (memRead || storeDone) ? stMem : stWriteback; // failed sc skips
        stMem:       if (dataGnt) state <= stMemWait;
        stMemWait:   if (memWrite || dataRvalid) state <= stWriteback;
        stWriteback: begin
          pc     <= nextPc;
          state  <= halt ? stIdle : stFetch;
          halted <= halt;
          if (isLr) resValid <= 1'b1;
          else if (isSc || (memWrite && aluResult == resAddr)) resValid <= 1'b0;
        end
        default:     state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stFetchWait && fetchRvalid) ir <= fetchRdata;
    if (dataRvalid) loadData <= dataRdata;
    if (state == stWriteback && isLr) resAddr <= aluResult;
  end

  assign fetchReq  = (state == stFetch);
  assign fetchAddr = pc;
  assign dataReq   = (state == stMem);
  assign dataWe    = memWrite;
  assign dataAddr  = aluResult;
  assign dataWdata = rdata2;

  assign retire      = (state == stWriteback);
  assign retirePc    = pc;
  assign retireRd    = regWrite ? ir.rType.rd : 5'd0;
  assign retireValue = wbValue;
  assign retireStore = retire && storeDone;
  assign retireAddr  = aluResult;
  assign retireData  = rdata2;

  assert property (@(posedge clk) disable iff (!rstN)
    retire |-> $past(state) == stExecute || $past(state) == stMemWait);
  assert property (@(posedge clk) disable iff (!rstN) !(dataReq && fetchReq));
  assert property (@(posedge clk) disable iff (!rstN)
    dataReq |-> dataAddr < memWords * 4 && dataAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* unifiedMem.sv */
`default_nettype none

module unifiedMem import rvCorePkg::*; #(
  parameter int memWords = 1024
) (
  input  logic                        clk,
  input  logic                        en,
  input  logic                        we,
  input  logic [$clog2(memWords)-1:0] addr,
  input  logic [xlen-1:0]             wdata,
  output logic [xlen-1:0]             rdata
);

  logic [xlen-1:0] mem [memWords];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr]; // held until the next read
      end
    end
  end

endmodule

`default_nettype wire

/* memArbiter.sv */
`default_nettype none

module memArbiter import rvCorePkg::*; #(
  parameter int memWords = 1024
) (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        hostReq,
  input  logic                        hostWe,
  input  logic [xlen-1:0]             hostAddr,
  input  logic [xlen-1:0]             hostWdata,
  input  logic                        fetchReq,
  input  logic [xlen-1:0]             fetchAddr,
  input  logic                        dataReq,
  input  logic                        dataWe,
  input  logic [xlen-1:0]             dataAddr,
  input  logic [xlen-1:0]             dataWdata,
  input  logic [xlen-1:0]             memRdata,
  output logic                        hostGnt,
  output logic                        fetchGnt,
  output logic                        fetchRvalid,
  output logic [xlen-1:0]             fetchRdata,
  output logic                        dataGnt,
  output logic                        dataRvalid,
  output logic [xlen-1:0]             dataRdata,
  output logic                        memEn,
  output logic                        memWe,
  output logic [$clog2(memWords)-1:0] memAddr,
  output logic [xlen-1:0]             memWdata
);

  localparam int addrW = $clog2(memWords);

  logic [xlen-1:0] selAddr; // byte address of the winner
  logic fetchOwn;
  logic dataOwn;

  assign hostGnt  = hostReq;
  assign dataGnt  = dataReq && !hostReq;
  assign fetchGnt = fetchReq && !hostReq && !dataReq;
  assign memEn    = hostGnt || dataGnt || fetchGnt;

  always_comb begin
    memWe    = 1'b0;
    selAddr  = fetchAddr;
    memWdata = dataWdata;
    if (hostGnt) begin
      memWe    = hostWe;
      selAddr  = hostAddr;
      memWdata = hostWdata;
    end else if (dataGnt) begin
      memWe   = dataWe;
      selAddr = dataAddr;
    end
  end

  assign memAddr = selAddr[addrW+1:2];

  // owner of the read in flight
  always_ff @(posedge clk) begin
    if (!rstN) begin
      fetchOwn <= 1'b0;
      dataOwn  <= 1'b0;
    end else begin
      fetchOwn <= fetchGnt;
      dataOwn  <= dataGnt && !dataWe;
    end
  end

  assign fetchRvalid = fetchOwn;
  assign dataRvalid  = dataOwn;
  assign fetchRdata  = memRdata;
  assign dataRdata   = memRdata;

  assert property (@(posedge clk) disable iff (!rstN) $onehot0({hostGnt, dataGnt, fetchGnt}));

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile import rvCorePkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            we,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] rdata1,
  output logic [xlen-1:0] rdata2
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (we && rd != 5'd0) begin // x0 never written
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

  // x0 stays zero across every write since reset
  assert property (@(posedge clk) disable iff (!rstN) (rs1 == 5'd0) |-> (rdata1 == '0));

endmodule

`default_nettype wire

/* aluUnit.sv */
`default_nettype none

module aluUnit import rvCorePkg::*; (
  input  aluOp_t          aluOp,
  input  logic [2:0]      func3,
  input  logic [6:0]      func7,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result,
  output logic            taken
);

  always_comb begin
    result = a + b;
    taken  = 1'b0;
    case (aluOp)
      aluReg, aluImm: begin
        case (func3)
          f3AddSub: result = (aluOp == aluReg && func7[5]) ? a - b : a + b; // no subi
          f3Sll:    result = a << b[4:0];
          f3Slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
          f3Sltu:   result = {{(xlen-1){1'b0}}, a < b};
          f3Xor:    result = a ^ b;
          f3SrlSra: begin
            if (func7[5]) result = $signed(a) >>> b[4:0];
            else result = a >> b[4:0];
          end
          f3Or:     result = a | b;
          default:  result = a & b;
        endcase
      end
      aluBranch: begin
        result = a - b;
        case (func3)
          f3Beq:   taken = (a == b);
          f3Bne:   taken = (a != b);
          f3Blt:   taken = ($signed(a) < $signed(b));
          f3Bge:   taken = ($signed(a) >= $signed(b));
          f3Bltu:  taken = (a < b);
          f3Bgeu:  taken = (a >= b);
          default: taken = 1'b0;
        endcase
      end
      aluAmo:  result = a; // address straight from rs1
      aluNone: result = b;
      default: result = a + b; // address and pc ops
    endcase
  end

endmodule

`default_nettype wire

/* control.sv */
`default_nettype none

module control import rvCorePkg::*; (
  input  rvInstr_t        instr,
  output logic            branch,
  output logic            jump,
  output logic            jumpRegister,
  output logic            memRead,
  output logic            memToReg,
  output logic            memWrite,
  output logic            aluSrc,
  output logic            pcToAlu,
  output logic            regWrite,
  output aluOp_t          aluOp,
  output logic [xlen-1:0] imm,
  output logic            isLr,
  output logic            isSc,
  output logic            halt
);

  logic [6:0] opcode;

  assign opcode = instr.rType.opcode;

  assign isLr = (opcode == opAmo) && (instr.rType.func7[6:2] == amoLr);
  assign isSc = (opcode == opAmo) && (instr.rType.func7[6:2] == amoSc);

  assign branch       = (opcode == opBranch);
  assign jump         = (opcode == opJal) || (opcode == opJalr);
  assign jumpRegister = (opcode == opJalr);
  assign memRead      = (opcode == opLoad) || isLr; // lw and lr.w
  assign memToReg     = (opcode == opLoad) || isLr;
  assign memWrite     = (opcode == opStore) || isSc; // sw and sc.w
  assign pcToAlu      = (opcode == opAuipc) || (opcode == opJal); // jalr adds rs1
  assign halt         = (opcode == opSystem); // ecall

  assign aluSrc = (opcode == opOpImm) || (opcode == opLoad) || (opcode == opStore) ||
                  (opcode == opJal) || (opcode == opJalr) || (opcode == opLui) ||
                  (opcode == opAuipc);

  assign regWrite = (opcode == opOpImm) || (opcode == opLoad) || (opcode == opOp) ||
                    (opcode == opJal) || (opcode == opJalr) || (opcode == opLui) ||
                    (opcode == opAuipc) || isLr || isSc;

  always_comb begin
    case (opcode)
      opLoad, opStore: aluOp = aluAddr;
      opBranch:        aluOp = aluBranch;
      opOp:            aluOp = aluReg;
      opJal, opJalr,
      opAuipc:         aluOp = aluPc;
      opAmo:           aluOp = aluAmo;
      opOpImm:         aluOp = aluImm;
      default:         aluOp = aluNone; // lui lands here, passes imm
    endcase
  end

  always_comb begin
    case (opcode)
      opLoad, opJalr, opOpImm: imm = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
      opStore:  imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
      opBranch: imm = {{19{instr.sType.immHi[6]}}, instr.sType.immHi[6], instr.sType.immLo[0],
                       instr.sType.immHi[5:0], instr.sType.immLo[4:1], 1'b0};
      opLui, opAuipc: imm = {instr.raw[31:12], 12'b0};
      opJal: imm = {{11{instr.raw[31]}}, instr.raw[31], instr.raw[19:12], instr.raw[20],
                    instr.raw[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

  localparam int xlen = 32;

  // major opcodes
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opAmo    = 7'b0101111;
  localparam logic [6:0] opSystem = 7'b1110011;

  typedef enum logic [2:0] {
    aluAddr   = 3'b000, // load/store address
    aluBranch = 3'b001,
    aluReg    = 3'b010,
    aluPc     = 3'b011, // pc or upper add
    aluAmo    = 3'b100,
    aluImm    = 3'b110,
    aluNone   = 3'b111
  } aluOp_t;

  // func3 codes of the ALU and of branches
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll    = 3'b001;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Sltu   = 3'b011;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3SrlSra = 3'b101;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Beq    = 3'b000;
  localparam logic [2:0] f3Bne    = 3'b001;
  localparam logic [2:0] f3Blt    = 3'b100;
  localparam logic [2:0] f3Bge    = 3'b101;
  localparam logic [2:0] f3Bltu   = 3'b110;
  localparam logic [2:0] f3Bgeu   = 3'b111;

  // func7[6:2] of the atomics
  localparam logic [4:0] amoLr = 5'b00010;
  localparam logic [4:0] amoSc = 5'b00011;

  typedef struct packed {
    logic [6:0] func7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] func3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rType_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  func3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iType_t;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] func3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sType_t;

  typedef union packed {
    logic [31:0] raw;
    rType_t      rType;
    iType_t      iType;
    sType_t      sType; // also carries the B-type bits
  } rvInstr_t;

endpackage

`default_nettype wire
